/* hdl/chroma_upsampler.sv */
// --------------------------------------------------------------------------
// Chroma upsampler
// Keeps six-sample U and V windows per line, interpolates odd chroma with
// the six-tap filter, removes offsets and flushes three steps at line end
// --------------------------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module chroma_upsampler (
        input  logic                 CLOCK_50_I,
        input  logic                 Resetn,
        input  logic                 pair_valid,
        input  csc_pkg::yuv_pair_t   pair_in,
        output logic                 job_valid,
        output csc_pkg::conv_job_t   job
);
        import csc_pkg::*;

        // Index 0 holds s[j-2], index 5 holds s[j+3]
        logic [5:0][PIXEL_W-1:0] u_win;
        logic [5:0][PIXEL_W-1:0] v_win;
        logic [5:0][PIXEL_W-1:0] u_next;
        logic [5:0][PIXEL_W-1:0] v_next;

        // Luma delay line, index 2 is the oldest pair
        logic [2:0][PIXEL_W-1:0] ye_dly;
        logic [2:0][PIXEL_W-1:0] yo_dly;

        // Pairs seen in this line, saturates at 3
        logic [1:0] line_cnt;
        logic [1:0] flush_phase;
        logic       flushing;
        logic       step;
        logic       emit;

        function automatic logic signed [CHROMA_W-1:0] odd_chroma(
                input logic [5:0][PIXEL_W-1:0] s
        );
                logic signed [PRODUCT_W-1:0] outer;
                logic signed [PRODUCT_W-1:0] inner;
                logic signed [PRODUCT_W-1:0] centre;
                logic signed [PRODUCT_W-1:0] acc;
                outer  = PRODUCT_W'(s[0]) + PRODUCT_W'(s[5]);
                inner  = PRODUCT_W'(s[1]) + PRODUCT_W'(s[4]);
                centre = PRODUCT_W'(s[2]) + PRODUCT_W'(s[3]);
                acc = FILT_C1 * outer - FILT_C2 * inner + FILT_C3 * centre + FILT_ROUND;
                return CHROMA_W'((acc >>> FILT_SHIFT) - CHROMA_OFFSET);
        endfunction

        function automatic logic signed [CHROMA_W-1:0] even_chroma(
                input logic [PIXEL_W-1:0] s
        );
                return CHROMA_W'($signed({1'b0, s}) - CHROMA_OFFSET);
        endfunction

        assign flushing = (flush_phase != 2'd0);
        assign step     = pair_valid | flushing;

        // Step k of the flush emits pair N-4+k when it exists
        assign emit = flushing ? (({1'b0, line_cnt} + {1'b0, flush_phase}) >= 3'd4)
                               : (pair_valid && line_cnt == 2'd3);

        always_comb begin
                if (flushing) begin
                        // Repeat the last sample of the line
                        u_next = {u_win[5], u_win[5:1]};
                        v_next = {v_win[5], v_win[5:1]};
                end else if (line_cnt == 2'd0) begin
                        u_next = {6{pair_in.u}};
                        v_next = {6{pair_in.v}};
                end else begin
                        u_next = {pair_in.u, u_win[5:1]};
                        v_next = {pair_in.v, v_win[5:1]};
                end
        end

        always_ff @(posedge CLOCK_50_I or negedge Resetn) begin
                if (!Resetn) begin
                        line_cnt    <= 2'd0;
                        flush_phase <= 2'd0;
                        job_valid   <= 1'b0;
                end else begin
                        job_valid <= emit;
                        if (flushing) begin
                                if (flush_phase == 2'd3) begin
                                        flush_phase <= 2'd0;
                                        line_cnt    <= 2'd0;
                                end else begin
                                        flush_phase <= flush_phase + 2'd1;
                                end
                        end else if (pair_valid) begin
                                if (line_cnt != 2'd3)
                                        line_cnt <= line_cnt + 2'd1;
                                if (pair_in.last)
                                        flush_phase <= 2'd1;
                        end
                end
        end

        always_ff @(posedge CLOCK_50_I) begin
                if (step) begin
                        u_win  <= u_next;
                        v_win  <= v_next;
                        ye_dly <= {ye_dly[1:0], pair_in.y_even};
                        yo_dly <= {yo_dly[1:0], pair_in.y_odd};
                end
                if (emit) begin
                        job.y_even <= ye_dly[2];
                        job.y_odd  <= yo_dly[2];
                        job.u_even <= even_chroma(u_next[2]);
                        job.u_odd  <= odd_chroma(u_next);
                        job.v_even <= even_chroma(v_next[2]);
                        job.v_odd  <= odd_chroma(v_next);
                end
        end

        // Input spacing must leave room for the line-end flush
        assert property (@(posedge CLOCK_50_I) disable iff (!Resetn)
                flushing |-> !pair_valid)
                else $error("pair arrived during line-end flush");

endmodule

`default_nettype wire

/* hdl/csc_pkg.sv */
// --------------------------------------------------------------------------
// YUV to RGB colour converter shared definitions
// Widths, filter and matrix constants, the pair, job and word types,
// and the colour clipping function used by the converter datapath
// --------------------------------------------------------------------------

`default_nettype none

package csc_pkg;

        // Sample and datapath widths
        localparam int PIXEL_W   = 8;
        localparam int WORD_W    = 16;
        localparam int CHROMA_W  = 16;
        localparam int PRODUCT_W = 32;

        localparam int LUMA_OFFSET   = 16;
        localparam int CHROMA_OFFSET = 128;

        // Six-tap interpolation, scaled by 256
        localparam int FILT_C1    = 21;
        localparam int FILT_C2    = 52;
        localparam int FILT_C3    = 159;
        localparam int FILT_ROUND = 128;
        localparam int FILT_SHIFT = 8;

        // Colour matrix, GU and GV are subtracted
        localparam int COEF_Y  = 76284;
        localparam int COEF_RV = 104595;
        localparam int COEF_GU = 25624;
        localparam int COEF_GV = 53281;
        localparam int COEF_BU = 132251;

        // Colour byte sits at bits 23..16 of a sum
        localparam int RGB_SHIFT = 16;

        localparam int FIFO_DEPTH = 8;

        // One input pixel pair with shared chroma
        typedef struct packed {
                logic [PIXEL_W-1:0] y_even;
                logic [PIXEL_W-1:0] y_odd;
                logic [PIXEL_W-1:0] u;
                logic [PIXEL_W-1:0] v;
                logic               last;
        } yuv_pair_t;

        // Upsampled pair, chroma already offset-removed
        typedef struct packed {
                logic [PIXEL_W-1:0]         y_even;
                logic [PIXEL_W-1:0]         y_odd;
                logic signed [CHROMA_W-1:0] u_even;
                logic signed [CHROMA_W-1:0] u_odd;
                logic signed [CHROMA_W-1:0] v_even;
                logic signed [CHROMA_W-1:0] v_odd;
        } conv_job_t;

        typedef logic [WORD_W-1:0] rgb_word_t;

        // Saturate a fixed-point sum to one colour byte
        function automatic logic [PIXEL_W-1:0] clip_color(
                input logic signed [PRODUCT_W-1:0] sum
        );
                if (sum[PRODUCT_W-1]) begin
                        return '0;
                end else if (|sum[PRODUCT_W-2:RGB_SHIFT+PIXEL_W]) begin
                        return '1;
                end else begin
                        return sum[RGB_SHIFT +: PIXEL_W];
                end
        endfunction

endpackage

`default_nettype wire

/* hdl/csc_top.sv */
// --------------------------------------------------------------------------
// YUV to RGB converter top
// Upsampler feeds the pair FIFO, the RGB converter drains it
// --------------------------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module csc_top (
        input  logic                 CLOCK_50_I,
        input  logic                 Resetn,
        input  logic                 pair_valid,
        input  csc_pkg::yuv_pair_t   pair_in,
        output logic                 word_valid,
        output csc_pkg::rgb_word_t   rgb_word
);
        import csc_pkg::*;

        logic      job_valid;
        conv_job_t job;
        logic      fifo_empty;
        conv_job_t fifo_head;
        logic      fifo_pop;

        chroma_upsampler u_upsampler (
                .CLOCK_50_I (CLOCK_50_I),
                .Resetn     (Resetn),
                .pair_valid (pair_valid),
                .pair_in    (pair_in),
                .job_valid  (job_valid),
                .job        (job)
        );

        pair_fifo u_fifo (
                .CLOCK_50_I (CLOCK_50_I),
                .Resetn     (Resetn),
                .push       (job_valid),
                .wr_data    (job),
                .pop        (fifo_pop),
                .head       (fifo_head),
                .empty      (fifo_empty)
        );

        rgb_converter u_converter (
                .CLOCK_50_I (CLOCK_50_I),
                .Resetn     (Resetn),
                .empty      (fifo_empty),
                .head       (fifo_head),
                .pop        (fifo_pop),
                .word_valid (word_valid),
                .rgb_word   (rgb_word)
        );

endmodule

`default_nettype wire

/* hdl/pair_fifo.sv */
// --------------------------------------------------------------------------
// Upsampled pair FIFO
// Circular buffer between upsampler and converter, absorbs flush bursts
// --------------------------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module pair_fifo #(
        parameter int DEPTH = csc_pkg::FIFO_DEPTH
) (
        input  logic                 CLOCK_50_I,
        input  logic                 Resetn,
        input  logic                 push,
        input  csc_pkg::conv_job_t   wr_data,
        input  logic                 pop,
        output csc_pkg::conv_job_t   head,
        output logic                 empty
);
        import csc_pkg::*;

        localparam int PTR_W = $clog2(DEPTH);
        localparam int CNT_W = $clog2(DEPTH + 1);

        conv_job_t        mem [DEPTH];
        logic [PTR_W-1:0] rd_ptr;
        logic [PTR_W-1:0] wr_ptr;
        logic [CNT_W-1:0] count;

        assign head  = mem[rd_ptr];
        assign empty = (count == '0);

        always_ff @(posedge CLOCK_50_I) begin
                if (push)
                        mem[wr_ptr] <= wr_data;
        end

        always_ff @(posedge CLOCK_50_I or negedge Resetn) begin
                if (!Resetn) begin
                        rd_ptr <= '0;
                        wr_ptr <= '0;
                        count  <= '0;
                end else begin
                        if (push)
                                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
                        if (pop)
                                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
                        if (push && !pop)
                                count <= count + 1'b1;
                        else if (!push && pop)
                                count <= count - 1'b1;
                end
        end

        assert property (@(posedge CLOCK_50_I) disable iff (!Resetn)
                push |-> (count != CNT_W'(DEPTH)))
                else $error("pair FIFO overflow");

        assert property (@(posedge CLOCK_50_I) disable iff (!Resetn)
                pop |-> (count != '0))
                else $error("pair FIFO underflow");

endmodule

`default_nettype wire

/* hdl/rgb_converter.sv */
// --------------------------------------------------------------------------
// RGB converter
// Pops upsampled pairs, runs the colour matrix, clips each colour and
// serialises the pair into three packed 16-bit words
// --------------------------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module rgb_converter (
        input  logic                 CLOCK_50_I,
        input  logic                 Resetn,
        input  logic                 empty,
        input  csc_pkg::conv_job_t   head,
        output logic                 pop,
        output logic                 word_valid,
        output csc_pkg::rgb_word_t   rgb_word
);
        import csc_pkg::*;

        logic [1:0] gap_cnt;
        logic       s1_valid;
        logic       s2_valid;
        logic [1:0] ser_phase;

        logic signed [PRODUCT_W-1:0] py_even;
        logic signed [PRODUCT_W-1:0] py_odd;
        logic signed [PRODUCT_W-1:0] prv_even;
        logic signed [PRODUCT_W-1:0] prv_odd;
        logic signed [PRODUCT_W-1:0] pgu_even;
        logic signed [PRODUCT_W-1:0] pgu_odd;
        logic signed [PRODUCT_W-1:0] pgv_even;
        logic signed [PRODUCT_W-1:0] pgv_odd;
        logic signed [PRODUCT_W-1:0] pbu_even;
        logic signed [PRODUCT_W-1:0] pbu_odd;

        logic [PIXEL_W-1:0] r_even;
        logic [PIXEL_W-1:0] g_even;
        logic [PIXEL_W-1:0] b_even;
        logic [PIXEL_W-1:0] r_odd;
        logic [PIXEL_W-1:0] g_odd;
        logic [PIXEL_W-1:0] b_odd;

        // One new pair every third cycle at most
        assign pop = !empty && (gap_cnt == 2'd0);

        always_ff @(posedge CLOCK_50_I or negedge Resetn) begin
                if (!Resetn) begin
                        gap_cnt    <= 2'd0;
                        s1_valid   <= 1'b0;
                        s2_valid   <= 1'b0;
                        ser_phase  <= 2'd0;
                        word_valid <= 1'b0;
                end else begin
                        s1_valid   <= pop;
                        s2_valid   <= s1_valid;
                        word_valid <= s2_valid || (ser_phase != 2'd0);
                        if (pop)
                                gap_cnt <= 2'd2;
                        else if (gap_cnt != 2'd0)
                                gap_cnt <= gap_cnt - 2'd1;
                        if (s2_valid)
                                ser_phase <= 2'd1;
                        else if (ser_phase == 2'd1)
                                ser_phase <= 2'd2;
                        else
                                ser_phase <= 2'd0;
                end
        end

        // Stage one, products straight from the FIFO head
        always_ff @(posedge CLOCK_50_I) begin
                if (pop) begin
                        py_even  <= COEF_Y * ($signed({1'b0, head.y_even}) - LUMA_OFFSET);
                        py_odd   <= COEF_Y * ($signed({1'b0, head.y_odd}) - LUMA_OFFSET);
                        prv_even <= COEF_RV * $signed(head.v_even);
                        prv_odd  <= COEF_RV * $signed(head.v_odd);
                        pgu_even <= COEF_GU * $signed(head.u_even);
                        pgu_odd  <= COEF_GU * $signed(head.u_odd);
                        pgv_even <= COEF_GV * $signed(head.v_even);
                        pgv_odd  <= COEF_GV * $signed(head.v_odd);
                        pbu_even <= COEF_BU * $signed(head.u_even);
                        pbu_odd  <= COEF_BU * $signed(head.u_odd);
                end
        end

        // Stage two, sums and clipping
        always_ff @(posedge CLOCK_50_I) begin
                if (s1_valid) begin
                        r_even <= clip_color(py_even + prv_even);
                        g_even <= clip_color(py_even - pgu_even - pgv_even);
                        b_even <= clip_color(py_even + pbu_even);
                        r_odd  <= clip_color(py_odd + prv_odd);
                        g_odd  <= clip_color(py_odd - pgu_odd - pgv_odd);
                        b_odd  <= clip_color(py_odd + pbu_odd);
                end
        end

        always_ff @(posedge CLOCK_50_I) begin
                if (s2_valid)
                        rgb_word <= {r_even, g_even};
                else if (ser_phase == 2'd1)
                        rgb_word <= {b_even, r_odd};
                else if (ser_phase == 2'd2)
                        rgb_word <= {g_odd, b_odd};
        end

        // Next pair must not reach the serialiser mid-pair
        assert property (@(posedge CLOCK_50_I) disable iff (!Resetn)
                s2_valid |-> (ser_phase == 2'd0))
                else $error("serialiser overrun");

endmodule

`default_nettype wire

/* project.f */
hdl/csc_pkg.sv
hdl/chroma_upsampler.sv
hdl/pair_fifo.sv
hdl/rgb_converter.sv
hdl/csc_top.sv
testbench/csc_tb.sv

/* testbench/csc_tb.sv */
// --------------------------------------------------------------------------
// Testbench for the YUV to RGB converter
// Reads pairs and expected words from the tests file, drives the DUT,
// checks every output word and counts them
// --------------------------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module csc_tb;
        import csc_pkg::*;

        localparam int WATCHDOG_MARGIN = 300;

        logic        CLOCK_50_I;
        logic        Resetn;
        logic        pair_valid;
        yuv_pair_t   pair_in;
        logic        word_valid;
        rgb_word_t   rgb_word;

        string       lines[$];
        logic [15:0] exp_q[$];
        int          total_pairs = 0;
        int          num_tests = 0;
        int          error_count = 0;
        int          word_count = 0;

        csc_top dut (
                .CLOCK_50_I (CLOCK_50_I),
                .Resetn     (Resetn),
                .pair_valid (pair_valid),
                .pair_in    (pair_in),
                .word_valid (word_valid),
                .rgb_word   (rgb_word)
        );

        initial begin
                CLOCK_50_I = 1'b0;
                forever #2 CLOCK_50_I = ~CLOCK_50_I;
        end

        task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                                   input string msg);
                if (actual !== expected) begin
                        $display("CHECK FAILED at %0t: %s, got %h expected %h",
                                 $time, msg, actual, expected);
                        error_count++;
                end
        endtask

        // One strobe, then the spacing the upsampler needs
        task automatic send_pair(input yuv_pair_t p);
                @(negedge CLOCK_50_I);
                pair_valid = 1'b1;
                pair_in    = p;
                @(negedge CLOCK_50_I);
                pair_valid = 1'b0;
                @(negedge CLOCK_50_I);
                if (p.last)
                        @(negedge CLOCK_50_I);
        endtask

        task automatic wait_drained();
                while (exp_q.size() != 0)
                        @(negedge CLOCK_50_I);
        endtask

        always @(negedge CLOCK_50_I) begin
                if (Resetn && word_valid) begin
                        word_count++;
                        if (exp_q.size() == 0) begin
                                $display("Unexpected extra output word %h at %0t", rgb_word, $time);
                                error_count++;
                        end else begin
                                check_value(rgb_word, exp_q.pop_front(), "output word");
                        end
                end
        end

        initial begin
                wait (total_pairs > 0);
                repeat (total_pairs * 3 + num_tests * 40 + WATCHDOG_MARGIN)
                        @(posedge CLOCK_50_I);
                $display("Watchdog timeout, %0d expected output words never arrived",
                         exp_q.size());
                $display("TESTS FAILED");
                $finish;
        end

        initial begin : main
                int          fd;
                string       line;
                string       name;
                string       cur_name;
                int          ye, yo, u, v, lst, w0, w1, w2;
                int          errs_at_start;
                int          tests_passed;
                int          tests_failed;
                yuv_pair_t   p;
                pair_valid    = 1'b0;
                pair_in       = '0;
                Resetn        = 1'b0;
                tests_passed  = 0;
                tests_failed  = 0;
                errs_at_start = 0;
                cur_name      = "";
                fd = $fopen("testbench/csc_tests.txt", "r");
                if (fd == 0) begin
                        $display("Could not open the test data file testbench/csc_tests.txt");
                        $display("TESTS FAILED");
                        $finish;
                end else begin
                        while (!$feof(fd)) begin
                                line = "";
                                void'($fgets(line, fd));
                                if (line.len() > 1 && line.getc(0) == "P")
                                        total_pairs++;
                                if (line.len() > 1 && (line.getc(0) == "P" || line.getc(0) == "T"))
                                        lines.push_back(line);
                                if (line.len() > 1 && line.getc(0) == "T")
                                        num_tests++;
                        end
                        $fclose(fd);

                        repeat (16) @(posedge CLOCK_50_I);
                        @(negedge CLOCK_50_I);
                        Resetn = 1'b1;

                        // Sentinel closes the last test
                        lines.push_back("T end_of_file");
                        foreach (lines[i]) begin
                                if (lines[i].getc(0) == "T") begin
                                        void'($sscanf(lines[i], "T %s", name));
                                        if (cur_name != "") begin
                                                wait_drained();
                                                if (error_count == errs_at_start) begin
                                                        tests_passed++;
                                                        $display("test %s: pass", cur_name);
                                                end else begin
                                                        tests_failed++;
                                                        $display("test %s: fail, %0d errors",
                                                                 cur_name, error_count - errs_at_start);
                                                end
                                        end
                                        cur_name      = name;
                                        errs_at_start = error_count;
                                end else if ($sscanf(lines[i], "P %h %h %h %h %h %h %h %h",
                                                     ye, yo, u, v, lst, w0, w1, w2) == 8) begin
                                        p.y_even = ye[7:0];
                                        p.y_odd  = yo[7:0];
                                        p.u      = u[7:0];
                                        p.v      = v[7:0];
                                        p.last   = lst[0];
                                        exp_q.push_back(w0[15:0]);
                                        exp_q.push_back(w1[15:0]);
                                        exp_q.push_back(w2[15:0]);
                                        send_pair(p);
                                end else begin
                                        $display("Malformed line in test data: %s", lines[i]);
                                        error_count++;
                                end
                        end

                        // Room for stray words after the last pair
                        repeat (20) @(negedge CLOCK_50_I);
                        check_value(word_count, 3 * total_pairs, "total word count");
                        $display("summary: %0d pass, %0d fail, %0d words, %0d errors",
                                 tests_passed, tests_failed, word_count, error_count);
                        if (error_count == 0 && tests_failed == 0)
                                $display("TESTS PASSED");
                        else
                                $display("TESTS FAILED");
                        $finish;
                end
        end

endmodule

`default_nettype wire

/* testbench/csc_tests.txt */
# T name | P y_even y_odd u v last word0 word1 word2 (hex)
# Words per pair are {R even, G even}, {B even, R odd}, {G odd, B odd}
T grey_line
P 10 20 80 80 0 0000 0012 1212
P 64 c8 80 80 0 6161 61d6 d6d6
P eb ff 80 80 0 fefe feff ffff
P 00 64 80 80 1 0000 0061 6161
T clip_short_lines
P 00 00 00 00 0 0087 0000 8700
P ff ff 00 00 1 49ff 1349 ff13
P 00 00 ff ff 0 b800 edb8 00ed
P ff ff ff ff 1 ff7d ffff 7dff
T chroma_ramp
P 80 80 40 80 0 829b 0182 980f
P 80 80 50 80 0 8295 2182 9133
P 80 80 60 80 0 828e 4182 8b51
P 80 80 70 80 0 8288 6282 8572
P 80 80 80 80 0 8282 8282 7f92
P 80 80 90 80 0 827c a282 79b0
P 80 80 a0 80 0 8275 c282 72d5
P 80 80 b0 80 1 826f e382 6fe5
T edge_two_lines
P 00 00 ff ff 0 b800 edb8 00ed
P ff ff ff ff 1 ff7d ffff 7dff
P 80 80 40 80 0 829b 0182 980f
P 80 80 50 80 0 8295 2182 9133
P 80 80 60 80 0 828e 4182 8b51
P 80 80 70 80 0 8288 6282 8572
P 80 80 80 80 0 8282 8282 7f92
P 80 80 90 80 0 827c a282 79b0
P 80 80 a0 80 0 8275 c282 72d5
P 80 80 b0 80 1 826f e382 6fe5
